/* source/fixed_point_pkg.sv */
package fixed_point_pkg;

  // Q4.12 operands and result
  localparam int sample_width = 16;
  localparam int frac_bits    = 12;

  // Full signed product of two sign-extended samples
  localparam int product_width = 2 * sample_width;

  // Product carries twice the fraction bits, so the slice
  // drops frac_bits from the bottom to return to Q4.12
  localparam int result_lsb = 2 * frac_bits - frac_bits;
  localparam int result_msb = result_lsb + sample_width - 1;

  // One data, grid or scale sample
  typedef logic signed [sample_width-1:0] sample_t;

  // Full-width product
  typedef logic signed [product_width-1:0] product_t;

endpackage

/* source/stream_pkg.sv */
package stream_pkg;

  // Input beat as held by the aligner registers
  typedef struct packed {
    fixed_point_pkg::sample_t value;
    logic                     last;
  } in_beat_t;

  // Result beat as held by the output register
  typedef struct packed {
    logic [fixed_point_pkg::sample_width-1:0] value;
    logic                                     last;
  } result_beat_t;

endpackage

/* source/stream_skid_buffer.sv */
`timescale 1ns/1ps

module stream_skid_buffer #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rst_n,

  input  logic     in_valid,
  output logic     in_ready,
  input  payload_t in_payload,

  output logic     out_valid,
  input  logic     out_ready,
  output payload_t out_payload
);

  payload_t main_payload;
  payload_t skid_payload;
  logic     main_valid;
  logic     skid_valid;
  logic     ready_reg;
  logic     ready_next;
  logic     main_load_in;
  logic     main_load_skid;
  logic     skid_load;

  // Stay open if downstream drains, or a slot is still free
  // after this cycle
  assign ready_next = out_ready | (~skid_valid & (~main_valid | ~in_valid));

  // Input goes straight to main when main empties or is empty
  assign main_load_in = ready_reg & (out_ready | ~main_valid);

  // Downstream stalled while we were still open
  assign skid_load = ready_reg & main_valid & ~out_ready;

  // Drain skid entry first once downstream moves again
  assign main_load_skid = ~ready_reg & out_ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      main_valid <= 1'b0;
      skid_valid <= 1'b0;
      ready_reg  <= 1'b0;
    end else begin
      ready_reg <= ready_next;

      if (main_load_in) begin
        main_valid <= in_valid;
      end else if (main_load_skid) begin
        main_valid <= skid_valid;
      end

      if (skid_load) begin
        skid_valid <= in_valid;
      end else if (main_load_skid) begin
        skid_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (main_load_in) begin
      main_payload <= in_payload;
    end else if (main_load_skid) begin
      main_payload <= skid_payload;
    end

    if (skid_load) begin
      skid_payload <= in_payload;
    end
  end

  assign in_ready    = ready_reg;
  assign out_valid   = main_valid;
  assign out_payload = main_payload;

endmodule

/* source/frame_aligner.sv */
`timescale 1ns/1ps

module frame_aligner (
  input  logic                     clk,
  input  logic                     rst_n,

  input  logic                     data_valid,
  output logic                     data_ready,
  input  fixed_point_pkg::sample_t data_value,
  input  logic                     data_last,

  input  logic                     grid_valid,
  output logic                     grid_ready,
  input  fixed_point_pkg::sample_t grid_value,
  input  logic                     grid_last,

  input  logic                     scale_valid,
  output logic                     scale_ready,
  input  fixed_point_pkg::sample_t scale_value,
  input  logic                     scale_last,

  output logic                     joint_valid,
  input  logic                     joint_ready,
  output logic                     joint_last,
  output fixed_point_pkg::sample_t data_sample,
  output fixed_point_pkg::sample_t grid_sample,
  output fixed_point_pkg::sample_t scale_sample
);

  // Stream index 0 is data, 1 is grid, 2 is scale
  logic [2:0]               src_valid;
  logic [2:0]               src_ready;
  logic [2:0]               src_last;
  fixed_point_pkg::sample_t src_value [3];

  logic [2:0]               reg_in_valid;
  logic [2:0]               reg_in_ready;
  logic [2:0]               reg_out_valid;
  stream_pkg::in_beat_t     reg_in  [3];
  stream_pkg::in_beat_t     reg_out [3];

  logic [2:0]               lock;
  logic                     fire;

  assign src_valid = {scale_valid, grid_valid, data_valid};
  assign src_last  = {scale_last, grid_last, data_last};

  assign src_value[0] = data_value;
  assign src_value[1] = grid_value;
  assign src_value[2] = scale_value;

  assign data_ready  = src_ready[0];
  assign grid_ready  = src_ready[1];
  assign scale_ready = src_ready[2];

  // Join of the three held beats
  assign joint_valid = &reg_out_valid;
  assign joint_last  = joint_valid & reg_out[0].last & reg_out[1].last & reg_out[2].last;
  assign fire        = joint_valid & joint_ready;

  for (genvar i = 0; i < 3; i++) begin : g_stream
    stream_pkg::in_beat_t src_beat;

    assign src_beat.value = src_value[i];
    assign src_beat.last  = src_last[i];

    // Holding a last beat while the other frames are still running
    assign lock[i] = reg_out_valid[i] & reg_out[i].last & ~joint_last;

    // A locked stream feeds its own beat back in as it pops,
    // so the last beat repeats until the longest frame ends
    assign reg_in[i]       = lock[i] ? reg_out[i] : src_beat;
    assign reg_in_valid[i] = lock[i] ? fire : src_valid[i];

    // Next frame stays out until the lock clears
    assign src_ready[i] = reg_in_ready[i] & ~lock[i];

    stream_skid_buffer #(
      .payload_t (stream_pkg::in_beat_t)
    ) i_input_buffer (
      .clk         (clk),
      .rst_n       (rst_n),
      .in_valid    (reg_in_valid[i]),
      .in_ready    (reg_in_ready[i]),
      .in_payload  (reg_in[i]),
      .out_valid   (reg_out_valid[i]),
      .out_ready   (fire),
      .out_payload (reg_out[i])
    );
  end

  assign data_sample  = reg_out[0].value;
  assign grid_sample  = reg_out[1].value;
  assign scale_sample = reg_out[2].value;

endmodule

/* source/sub_mult_datapath.sv */
`timescale 1ns/1ps

module sub_mult_datapath (
  input  fixed_point_pkg::sample_t                 data_sample,
  input  fixed_point_pkg::sample_t                 grid_sample,
  input  fixed_point_pkg::sample_t                 scale_sample,
  output logic [fixed_point_pkg::sample_width-1:0] result_value
);

  fixed_point_pkg::sample_t  diff;
  fixed_point_pkg::product_t diff_ext;
  fixed_point_pkg::product_t scale_ext;
  fixed_point_pkg::product_t product;

  // Difference wraps to sample width
  assign diff = data_sample - grid_sample;

  // Sign extension to the full product width
  assign diff_ext = {
    {(fixed_point_pkg::product_width - fixed_point_pkg::sample_width)
      {diff[fixed_point_pkg::sample_width-1]}},
    diff
  };
  assign scale_ext = {
    {(fixed_point_pkg::product_width - fixed_point_pkg::sample_width)
      {scale_sample[fixed_point_pkg::sample_width-1]}},
    scale_sample
  };

  // Exact, a 16x16 signed product fits in 32 bits
  assign product = diff_ext * scale_ext;

  // Back to Q4.12, upper bits are dropped
  assign result_value = product[fixed_point_pkg::result_msb:fixed_point_pkg::result_lsb];

endmodule

/* source/sub_mult.sv */
`timescale 1ns/1ps

module sub_mult (
  input  logic                                     clk,
  input  logic                                     rst_n,

  input  logic                                     data_valid,
  output logic                                     data_ready,
  input  fixed_point_pkg::sample_t                 data_value,
  input  logic                                     data_last,

  input  logic                                     grid_valid,
  output logic                                     grid_ready,
  input  fixed_point_pkg::sample_t                 grid_value,
  input  logic                                     grid_last,

  input  logic                                     scale_valid,
  output logic                                     scale_ready,
  input  fixed_point_pkg::sample_t                 scale_value,
  input  logic                                     scale_last,

  output logic                                     result_valid,
  input  logic                                     result_ready,
  output logic [fixed_point_pkg::sample_width-1:0] result_value,
  output logic                                     result_last
);

  logic                                     joint_valid;
  logic                                     joint_ready;
  logic                                     joint_last;
  fixed_point_pkg::sample_t                 data_sample;
  fixed_point_pkg::sample_t                 grid_sample;
  fixed_point_pkg::sample_t                 scale_sample;
  logic [fixed_point_pkg::sample_width-1:0] joint_value;
  stream_pkg::result_beat_t                 joint_beat;
  stream_pkg::result_beat_t                 result_beat;

  // Input registers and frame alignment
  frame_aligner i_frame_aligner (
    .clk          (clk),
    .rst_n        (rst_n),
    .data_valid   (data_valid),
    .data_ready   (data_ready),
    .data_value   (data_value),
    .data_last    (data_last),
    .grid_valid   (grid_valid),
    .grid_ready   (grid_ready),
    .grid_value   (grid_value),
    .grid_last    (grid_last),
    .scale_valid  (scale_valid),
    .scale_ready  (scale_ready),
    .scale_value  (scale_value),
    .scale_last   (scale_last),
    .joint_valid  (joint_valid),
    .joint_ready  (joint_ready),
    .joint_last   (joint_last),
    .data_sample  (data_sample),
    .grid_sample  (grid_sample),
    .scale_sample (scale_sample)
  );

  sub_mult_datapath i_sub_mult_datapath (
    .data_sample  (data_sample),
    .grid_sample  (grid_sample),
    .scale_sample (scale_sample),
    .result_value (joint_value)
  );

  assign joint_beat.value = joint_value;
  assign joint_beat.last  = joint_last;

  // Output register
  stream_skid_buffer #(
    .payload_t (stream_pkg::result_beat_t)
  ) i_result_buffer (
    .clk         (clk),
    .rst_n       (rst_n),
    .in_valid    (joint_valid),
    .in_ready    (joint_ready),
    .in_payload  (joint_beat),
    .out_valid   (result_valid),
    .out_ready   (result_ready),
    .out_payload (result_beat)
  );

  assign result_value = result_beat.value;
  assign result_last  = result_beat.last;

endmodule

/* sim/sub_mult_tb.sv */
`timescale 1ns/1ps

module sub_mult_tb;

  localparam int max_beats   = 256;
  localparam int max_frames  = 32;
  // Largest output beat count of all tests together
  localparam int total_beats = 8 + 7 + 19 + 20 * 6;
  localparam int timeout_ns  = total_beats * 20 * 8;

  logic                                     clk;
  logic                                     rst_n;
  logic [2:0]                               in_valid;
  logic [2:0]                               in_ready;
  logic [2:0]                               in_last;
  fixed_point_pkg::sample_t                 in_value [3];
  logic                                     result_valid;
  logic                                     result_ready;
  logic [fixed_point_pkg::sample_width-1:0] result_value;
  logic                                     result_last;

  // Stimulus per stream with 0 as data, 1 as grid and 2 as scale
  fixed_point_pkg::sample_t stim_value  [3][max_beats];
  int                       frame_len   [3][max_frames];
  int                       value_count [3];
  int                       frame_count;

  stream_pkg::result_beat_t exp_q [$];
  stream_pkg::result_beat_t got_q [$];
  int                       exp_len_q [$];

  int error_count;
  int tests_run;
  int tests_failed;

  sub_mult i_sub_mult (
    .clk          (clk),
    .rst_n        (rst_n),
    .data_valid   (in_valid[0]),
    .data_ready   (in_ready[0]),
    .data_value   (in_value[0]),
    .data_last    (in_last[0]),
    .grid_valid   (in_valid[1]),
    .grid_ready   (in_ready[1]),
    .grid_value   (in_value[1]),
    .grid_last    (in_last[1]),
    .scale_valid  (in_valid[2]),
    .scale_ready  (in_ready[2]),
    .scale_value  (in_value[2]),
    .scale_last   (in_last[2]),
    .result_valid (result_valid),
    .result_ready (result_ready),
    .result_value (result_value),
    .result_last  (result_last)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  initial begin
    #(timeout_ns);
    $display("Timeout: the run did not finish within %0d ns", timeout_ns);
    $display("Finished with errors");
    $finish;
  end

  // Drive point 1 ns after the rising edge
  task automatic tick();
    @(posedge clk);
    #1;
  endtask

  task automatic check_result(input string name, input stream_pkg::result_beat_t expected,
                              input stream_pkg::result_beat_t actual);
    if (actual !== expected) begin
      error_count++;
      $display("CHECK FAILED %s: expected value %h last %b, actual value %h last %b",
               name, expected.value, expected.last, actual.value, actual.last);
    end
  endtask

  task automatic check_count(input string name, input int expected, input int actual);
    if (actual != expected) begin
      error_count++;
      $display("CHECK FAILED %s: expected %0d beats, actual %0d beats", name, expected, actual);
    end
  endtask

  task automatic check_flag(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      error_count++;
      $display("CHECK FAILED %s: expected %b, actual %b", name, expected, actual);
    end
  endtask

  // Wrapped difference times scale, sliced back to Q4.12
  function automatic logic [fixed_point_pkg::sample_width-1:0] expected_value(
      input fixed_point_pkg::sample_t d, input fixed_point_pkg::sample_t g,
      input fixed_point_pkg::sample_t s);
    fixed_point_pkg::sample_t diff;
    int                       prod;
    diff = d - g;
    prod = int'(diff) * int'(s);
    return 16'(prod >>> fixed_point_pkg::frac_bits);
  endfunction

  task automatic clear_stimulus();
    frame_count = 0;
    value_count = '{0, 0, 0};
  endtask

  task automatic add_frame(input int ld, input int lg, input int ls);
    int lens [3];
    lens = '{ld, lg, ls};
    for (int s = 0; s < 3; s++) begin
      frame_len[s][frame_count] = lens[s];
      for (int i = 0; i < lens[s]; i++) begin
        stim_value[s][value_count[s]] = fixed_point_pkg::sample_t'($urandom);
        value_count[s]++;
      end
    end
    frame_count++;
  endtask

  // Reference join where a short frame repeats its last beat
  task automatic build_expected();
    int                       base [3];
    int                       pick [3];
    int                       len;
    stream_pkg::result_beat_t beat;
    base = '{0, 0, 0};
    exp_q.delete();
    exp_len_q.delete();
    for (int f = 0; f < frame_count; f++) begin
      len = frame_len[0][f];
      for (int s = 1; s < 3; s++) begin
        if (frame_len[s][f] > len) len = frame_len[s][f];
      end
      exp_len_q.push_back(len);
      for (int i = 0; i < len; i++) begin
        for (int s = 0; s < 3; s++) begin
          pick[s] = base[s] + ((i < frame_len[s][f]) ? i : frame_len[s][f] - 1);
        end
        beat.value = expected_value(stim_value[0][pick[0]], stim_value[1][pick[1]],
                                    stim_value[2][pick[2]]);
        beat.last  = (i == len - 1);
        exp_q.push_back(beat);
      end
      for (int s = 0; s < 3; s++) begin
        base[s] += frame_len[s][f];
      end
    end
  endtask

  task automatic drive_stream(input int s, input bit gaps);
    int idx;
    bit taken;
    idx = 0;
    for (int f = 0; f < frame_count; f++) begin
      for (int i = 0; i < frame_len[s][f]; i++) begin
        while (gaps && $urandom_range(3) == 0) begin
          in_valid[s] = 1'b0;
          tick();
        end
        in_valid[s] = 1'b1;
        in_value[s] = stim_value[s][idx];
        in_last[s]  = (i == frame_len[s][f] - 1);
        // Ready is registered, so it holds until the next edge
        do begin
          taken = in_ready[s];
          tick();
        end while (!taken);
        idx++;
      end
    end
    in_valid[s] = 1'b0;
  endtask

  task automatic collect_frames(input bit stalls);
    int                       frames_seen;
    stream_pkg::result_beat_t beat;
    frames_seen = 0;
    while (frames_seen < frame_count) begin
      result_ready = stalls ? ($urandom_range(2) != 0) : 1'b1;
      if (result_valid && result_ready) begin
        beat.value = result_value;
        beat.last  = result_last;
        got_q.push_back(beat);
        if (result_last) frames_seen++;
      end
      tick();
    end
    result_ready = 1'b1;
  endtask

  task automatic run_frames(input string name, input bit gaps, input bit stalls);
    int count;
    int frame;
    build_expected();
    got_q.delete();
    fork
      drive_stream(0, gaps);
      drive_stream(1, gaps);
      drive_stream(2, gaps);
      collect_frames(stalls);
    join
    check_count({name, " total"}, exp_q.size(), got_q.size());
    for (int i = 0; i < exp_q.size() && i < got_q.size(); i++) begin
      check_result(name, exp_q[i], got_q[i]);
    end
    count = 0;
    frame = 0;
    foreach (got_q[i]) begin
      count++;
      if (got_q[i].last) begin
        if (frame < exp_len_q.size()) check_count(name, exp_len_q[frame], count);
        frame++;
        count = 0;
      end
    end
    // Output stays quiet once all frames are out
    repeat (6) begin
      check_flag({name, " result_valid after last frame"}, 1'b0, result_valid);
      tick();
    end
  endtask

  task automatic report_test(input string name, input int errors_before);
    tests_run++;
    if (error_count == errors_before) begin
      $display("Test %s passed", name);
    end else begin
      tests_failed++;
      $display("Test %s failed with %0d errors", name, error_count - errors_before);
    end
  endtask

  task automatic test_reset_idle();
    int errors_before;
    errors_before = error_count;
    tick();
    check_flag("reset_idle data_ready", 1'b1, in_ready[0]);
    check_flag("reset_idle grid_ready", 1'b1, in_ready[1]);
    check_flag("reset_idle scale_ready", 1'b1, in_ready[2]);
    repeat (8) begin
      check_flag("reset_idle result_valid", 1'b0, result_valid);
      tick();
    end
    report_test("reset_idle", errors_before);
  endtask

  task automatic test_equal_frames();
    fixed_point_pkg::sample_t d [8] = '{16'sh7fff, 16'sh8000, 16'sh1000, 16'shf800,
                                        16'sh0000, 16'sh7fff, 16'sh4000, 16'sh8000};
    fixed_point_pkg::sample_t g [8] = '{16'sh8000, 16'sh7fff, 16'sh0000, 16'sh0800,
                                        16'sh8000, 16'sh0000, 16'shc000, 16'sh0001};
    fixed_point_pkg::sample_t s [8] = '{16'sh1000, 16'sh1000, 16'sh7fff, 16'sh8000,
                                        16'sh1000, 16'sh7fff, 16'sh2000, 16'shf000};
    int                       errors_before;
    errors_before = error_count;
    clear_stimulus();
    add_frame(8, 8, 8);
    for (int i = 0; i < 8; i++) begin
      stim_value[0][i] = d[i];
      stim_value[1][i] = g[i];
      stim_value[2][i] = s[i];
    end
    run_frames("equal_frames", 1'b0, 1'b0);
    report_test("equal_frames", errors_before);
  endtask

  task automatic test_unequal_frames();
    int errors_before;
    errors_before = error_count;
    clear_stimulus();
    add_frame(5, 1, 3);
    add_frame(2, 2, 2);
    run_frames("unequal_frames", 1'b0, 1'b0);
    report_test("unequal_frames", errors_before);
  endtask

  task automatic test_back_pressure();
    int errors_before;
    errors_before = error_count;
    clear_stimulus();
    add_frame(3, 4, 2);
    add_frame(4, 4, 4);
    add_frame(1, 5, 2);
    add_frame(6, 1, 1);
    run_frames("back_pressure", 1'b0, 1'b1);
    report_test("back_pressure", errors_before);
  endtask

  task automatic test_random_traffic();
    int errors_before;
    errors_before = error_count;
    clear_stimulus();
    repeat (20) begin
      add_frame(int'($urandom_range(6, 1)), int'($urandom_range(6, 1)),
                int'($urandom_range(6, 1)));
    end
    run_frames("random_traffic", 1'b1, 1'b1);
    report_test("random_traffic", errors_before);
  endtask

  initial begin
    void'($urandom(23123));
    error_count  = 0;
    tests_run    = 0;
    tests_failed = 0;
    rst_n        = 1'b0;
    in_valid     = '0;
    in_last      = '0;
    result_ready = 1'b0;
    for (int s = 0; s < 3; s++) begin
      in_value[s] = '0;
    end
    repeat (5) @(posedge clk);
    #1;
    rst_n = 1'b1;

    test_reset_idle();
    test_equal_frames();
    test_unequal_frames();
    test_back_pressure();
    test_random_traffic();

    $display("Tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed,
             error_count);
    if (error_count == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

/* src.f */
source/fixed_point_pkg.sv
source/stream_pkg.sv
source/stream_skid_buffer.sv
source/frame_aligner.sv
source/sub_mult_datapath.sv
source/sub_mult.sv
sim/sub_mult_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the sub_mult testbench with Verilator

set -u

cd "$(dirname "$0")" || exit 1

build_dir="obj_dir"
sim_bin="sub_mult_sim"

verilator --binary --timing --timescale 1ns/1ps \
  -f src.f \
  --top-module sub_mult_tb \
  -Mdir "$build_dir" \
  -o "$sim_bin"
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

output="$("./$build_dir/$sim_bin")"
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx "Finished with no errors"; then
  echo "Simulation passed"
  exit 0
else
  echo "Simulation failed"
  exit 1
fi
